// File: compile.f
hw/tile_dma_pkg.sv
hw/layer_cfg_decoder.sv
hw/tile_loop_sequencer.sv
hw/dma_addr_generator.sv
hw/dma_cmd_issuer.sv
hw/tile_dma_top.sv
testbench/tb_tile_dma.sv

// File: Bender.yml
package:
  name: tile_dma
  description: "Tile fetch address unit issuing 2D DMA reads for a small CNN accelerator"

sources:
  - files:
      - hw/tile_dma_pkg.sv
      - hw/layer_cfg_decoder.sv
      - hw/tile_loop_sequencer.sv
      - hw/dma_addr_generator.sv
      - hw/dma_cmd_issuer.sv
      - hw/tile_dma_top.sv
  - target: test
    files:
      - testbench/tb_tile_dma.sv

// File: testbench/tb_tile_dma.sv
`timescale 1ns/10ps
/*
 * tile dma testbench
 * directed fetches against a reference command list, with a DMA model
 * that holds dma_busy for a random number of cycles after each strobe
 */
module tb_tile_dma;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    // commands over all accepted fetches, and number of fetch attempts
    localparam int TOTAL_CMDS   = 30;
    localparam int RUNS         = 9;
    // strobe, up to 4 busy cycles and the gap per command
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_CMDS * 6 + RUNS * 16 + 100;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      start;
    tile_dma_pkg::layer_cfg_t  cfg;
    tile_dma_pkg::fetch_kind_t kind;
    logic                      dma_busy;
    logic                      busy;
    logic                      done;
    logic                      cfg_error;
    logic                      dma_cmd_valid;
    tile_dma_pkg::dma_cmd_t    dma_cmd;

    // expected and strobed command lists
    tile_dma_pkg::dma_cmd_t    exp_q[$];
    tile_dma_pkg::dma_cmd_t    got_q[$];
    logic [31:0]               lcg_state = 32'd9321;

    tile_dma_top i_tile_dma_top (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .cfg           (cfg),
        .kind          (kind),
        .dma_busy      (dma_busy),
        .busy          (busy),
        .done          (done),
        .cfg_error     (cfg_error),
        .dma_cmd_valid (dma_cmd_valid),
        .dma_cmd       (dma_cmd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int clip_extent(input int tile, input int remaining);
        return (remaining < tile) ? remaining : tile;
    endfunction

    function automatic string cmd_text(input tile_dma_pkg::dma_cmd_t c);
        return $sformatf("addr=%h len=%h stride=%h count=%h", c.addr, c.len, c.stride, c.count);
    endfunction

    // fixed base addresses, only the shape varies per test
    function automatic tile_dma_pkg::layer_cfg_t make_layer_cfg(
        input tile_dma_pkg::layer_type_t lt,
        input int in_r, input int in_c, input int in_d, input int out_k,
        input int tile_r, input int tile_d, input int tile_k
    );
        tile_dma_pkg::layer_cfg_t c;
        c.layer_type  = lt;
        c.in_r        = tile_dma_pkg::dim_t'(in_r);
        c.in_c        = tile_dma_pkg::dim_t'(in_c);
        c.in_d        = tile_dma_pkg::dim_t'(in_d);
        c.out_k       = tile_dma_pkg::dim_t'(out_k);
        c.tile_r      = tile_dma_pkg::dim_t'(tile_r);
        c.tile_d      = tile_dma_pkg::dim_t'(tile_d);
        c.tile_k      = tile_dma_pkg::dim_t'(tile_k);
        c.base_ifmap  = 32'h1000_0000;
        c.base_weight = 32'h2000_0400;
        c.base_bias   = 32'h3000_0080;
        return c;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic compare_cmd(input string name, input tile_dma_pkg::dma_cmd_t expected,
                               input tile_dma_pkg::dma_cmd_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR at %0t: %s expected %s, actual %s",
                                     $time, name, cmd_text(expected), cmd_text(actual)));
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR at %0t: %s expected %b, actual %b",
                                     $time, name, expected, actual));
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    task automatic build_expected(input tile_dma_pkg::layer_cfg_t c,
                                  input tile_dma_pkg::fetch_kind_t k);
        tile_dma_pkg::dma_cmd_t cmd;
        int db;
        int r0;
        int d0;
        int k0;
        int rows;
        int chans;
        int filts;
        int first;
        int last;
        logic is_dw;
        db    = tile_dma_pkg::DATA_BYTES;
        is_dw = (c.layer_type == tile_dma_pkg::DW);
        exp_q.delete();
        if (k == tile_dma_pkg::FETCH_IFMAP) begin
            // channels outer, rows inner
            for (d0 = 0; d0 < c.in_d; d0 += c.tile_d) begin
                for (r0 = 0; r0 < c.in_r; r0 += c.tile_r) begin
                    rows  = clip_extent(c.tile_r, c.in_r - r0);
                    chans = clip_extent(c.tile_d, c.in_d - d0);
                    first = r0;
                    last  = r0 + rows - 1;
                    if (is_dw) begin
                        // one halo row each side, clamped to the map
                        first = (r0 == 0) ? 0 : r0 - 1;
                        last  = (r0 + rows > c.in_r - 1) ? c.in_r - 1 : r0 + rows;
                    end
                    cmd.addr   = c.base_ifmap + d0 * c.in_r * c.in_c * db + first * c.in_c * db;
                    cmd.len    = tile_dma_pkg::len_t'((last - first + 1) * c.in_c * db);
                    cmd.stride = tile_dma_pkg::len_t'(c.in_r * c.in_c * db);
                    cmd.count  = tile_dma_pkg::cnt_t'(chans);
                    exp_q.push_back(cmd);
                end
            end
        end else if (k == tile_dma_pkg::FETCH_WEIGHT && !is_dw) begin
            // filters outer, channels inner
            for (k0 = 0; k0 < c.out_k; k0 += c.tile_k) begin
                for (d0 = 0; d0 < c.in_d; d0 += c.tile_d) begin
                    chans      = clip_extent(c.tile_d, c.in_d - d0);
                    filts      = clip_extent(c.tile_k, c.out_k - k0);
                    cmd.addr   = c.base_weight + (k0 * c.in_d + d0) * db;
                    cmd.len    = tile_dma_pkg::len_t'(chans * db);
                    cmd.stride = tile_dma_pkg::len_t'(c.in_d * db);
                    cmd.count  = tile_dma_pkg::cnt_t'(filts);
                    exp_q.push_back(cmd);
                end
            end
        end else if (k == tile_dma_pkg::FETCH_WEIGHT) begin
            // whole 3x3 kernels per channel tile
            for (d0 = 0; d0 < c.in_d; d0 += c.tile_d) begin
                chans      = clip_extent(c.tile_d, c.in_d - d0);
                cmd.addr   = c.base_weight + d0 * tile_dma_pkg::KERNEL_TAPS * db;
                cmd.len    = tile_dma_pkg::len_t'(chans * tile_dma_pkg::KERNEL_TAPS * db);
                cmd.stride = '0;
                cmd.count  = 8'd1;
                exp_q.push_back(cmd);
            end
        end else begin
            cmd.addr   = c.base_bias;
            cmd.len    = tile_dma_pkg::len_t'((is_dw ? c.in_d : c.out_k) *
                                              tile_dma_pkg::PSUM_BYTES);
            cmd.stride = '0;
            cmd.count  = 8'd1;
            exp_q.push_back(cmd);
        end
    endtask

    // --------------------
    // DMA model
    // --------------------
    initial begin : dma_model
        int busy_left;
        busy_left = 0;
        dma_busy  = 1'b0;
        forever begin
            @(negedge clk);
            // busy begins the cycle after the strobe
            dma_busy = (busy_left != 0);
            if (busy_left != 0) begin
                busy_left--;
            end
            if (dma_cmd_valid === 1'b1) begin
                got_q.push_back(dma_cmd);
                busy_left = 1 + (lcg_next() % 4);
            end
        end
    end

    // --------------------
    // fetch drivers
    // --------------------
    // one accepted fetch, optionally with a second start while busy
    task automatic run_fetch(input tile_dma_pkg::layer_cfg_t c,
                             input tile_dma_pkg::fetch_kind_t k, input bit intrude);
        tile_dma_pkg::layer_cfg_t other;
        int cycles;
        int idx;
        int n_exp;
        int n_got;
        if (got_q.size() != 0) begin
            report_failure($sformatf("%0d command(s) strobed outside a fetch", got_q.size()));
        end
        build_expected(c, k);
        n_exp = exp_q.size();
        // would show up as a foreign bias command if accepted
        other           = make_layer_cfg(tile_dma_pkg::PW, 5, 5, 5, 5, 1, 1, 1);
        other.base_bias = 32'h7777_0000;
        @(negedge clk);
        start = 1'b1;
        cfg   = c;
        kind  = k;
        @(negedge clk);
        start = 1'b0;
        compare_flag("busy", 1'b1, busy);
        cycles = 0;
        while (done !== 1'b1) begin
            compare_flag("cfg_error", 1'b0, cfg_error);
            start = 1'b0;
            if (intrude && cycles == 2) begin
                compare_flag("busy", 1'b1, busy);
                start = 1'b1;
                cfg   = other;
                kind  = tile_dma_pkg::FETCH_BIAS;
            end
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        // single done pulse, then busy drops
        @(negedge clk);
        compare_flag("done", 1'b0, done);
        compare_flag("busy", 1'b0, busy);
        n_got = got_q.size();
        idx   = 0;
        while (exp_q.size() != 0 && got_q.size() != 0) begin
            compare_cmd($sformatf("dma_cmd[%0d]", idx), exp_q.pop_front(), got_q.pop_front());
            idx++;
        end
        if (n_got != n_exp) begin
            report_failure($sformatf("wrong number of commands: expected %0d, got %0d",
                                     n_exp, n_got));
        end
    endtask

    // rejected descriptor, error one cycle after start and nothing else
    task automatic check_rejected(input tile_dma_pkg::layer_cfg_t c,
                                  input tile_dma_pkg::fetch_kind_t k);
        int i;
        @(negedge clk);
        start = 1'b1;
        cfg   = c;
        kind  = k;
        @(negedge clk);
        start = 1'b0;
        compare_flag("cfg_error", 1'b1, cfg_error);
        compare_flag("busy", 1'b0, busy);
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            compare_flag("cfg_error", 1'b0, cfg_error);
            compare_flag("busy", 1'b0, busy);
            compare_flag("dma_cmd_valid", 1'b0, dma_cmd_valid);
            compare_flag("done", 1'b0, done);
        end
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_pw_ifmap();
        $display("test: pw ifmap, partial last row tile");
        run_fetch(make_layer_cfg(tile_dma_pkg::PW, 10, 8, 6, 4, 4, 4, 2),
                  tile_dma_pkg::FETCH_IFMAP, 1'b0);
    endtask

    task automatic test_pw_weight();
        $display("test: pw weight, clipped d and k tiles");
        run_fetch(make_layer_cfg(tile_dma_pkg::PW, 5, 5, 10, 7, 2, 4, 3),
                  tile_dma_pkg::FETCH_WEIGHT, 1'b0);
    endtask

    task automatic test_dw_ifmap();
        $display("test: dw ifmap halo clamping");
        run_fetch(make_layer_cfg(tile_dma_pkg::DW, 9, 6, 3, 3, 3, 2, 1),
                  tile_dma_pkg::FETCH_IFMAP, 1'b0);
    endtask

    task automatic test_dw_weight_bias();
        tile_dma_pkg::layer_cfg_t dw_cfg;
        $display("test: dw weight and bias for both layer types");
        // in_d and out_k differ so each bias length rule is visible
        dw_cfg = make_layer_cfg(tile_dma_pkg::DW, 4, 4, 11, 6, 2, 4, 1);
        run_fetch(dw_cfg, tile_dma_pkg::FETCH_WEIGHT, 1'b0);
        run_fetch(dw_cfg, tile_dma_pkg::FETCH_BIAS, 1'b0);
        run_fetch(make_layer_cfg(tile_dma_pkg::PW, 4, 4, 5, 7, 2, 2, 3),
                  tile_dma_pkg::FETCH_BIAS, 1'b0);
    endtask

    task automatic test_bad_descriptor();
        $display("test: bad descriptors and start while busy");
        // zero channel tile, then row tile taller than the map
        check_rejected(make_layer_cfg(tile_dma_pkg::PW, 10, 8, 6, 4, 4, 0, 2),
                       tile_dma_pkg::FETCH_IFMAP);
        check_rejected(make_layer_cfg(tile_dma_pkg::PW, 10, 8, 6, 4, 12, 4, 2),
                       tile_dma_pkg::FETCH_IFMAP);
        run_fetch(make_layer_cfg(tile_dma_pkg::PW, 10, 8, 6, 4, 5, 3, 2),
                  tile_dma_pkg::FETCH_IFMAP, 1'b1);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst   = 1'b1;
        start = 1'b0;
        cfg   = '0;
        kind  = tile_dma_pkg::FETCH_IFMAP;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        compare_flag("busy", 1'b0, busy);
        compare_flag("done", 1'b0, done);
        compare_flag("cfg_error", 1'b0, cfg_error);
        compare_flag("dma_cmd_valid", 1'b0, dma_cmd_valid);
        test_pw_ifmap();
        test_pw_weight();
        test_dw_ifmap();
        test_dw_weight_bias();
        test_bad_descriptor();
        repeat (4) @(negedge clk);
        if (got_q.size() != 0) begin
            report_failure($sformatf("%0d command(s) strobed after the last fetch", got_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    // hang guard, sized from the command total
    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        report_failure("watchdog: the DUT did not finish all fetches in time");
    end

endmodule

// File: hw/tile_dma_top.sv
`timescale 1ns/10ps
/*
 * tile dma fetch unit top
 * decoder, loop sequencer, address generator and command issuer
 */
module tile_dma_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  tile_dma_pkg::layer_cfg_t  cfg,
    input  tile_dma_pkg::fetch_kind_t kind,
    input  logic                      dma_busy,
    output logic                      busy,
    output logic                      done,
    output logic                      cfg_error,
    output logic                      dma_cmd_valid,
    output tile_dma_pkg::dma_cmd_t    dma_cmd
);

    logic                      cfg_load;
    tile_dma_pkg::layer_cfg_t  cfg_q;
    tile_dma_pkg::fetch_kind_t kind_q;
    logic                      coord_valid;
    tile_dma_pkg::tile_coord_t coord;
    logic                      coord_last;
    logic                      cmd_in_valid;
    tile_dma_pkg::dma_cmd_t    cmd_in;
    logic                      cmd_in_last;
    logic                      stall;

    // --------------------
    // decode
    // --------------------
    layer_cfg_decoder i_layer_cfg_decoder (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cfg       (cfg),
        .kind      (kind),
        .done      (done),
        .busy      (busy),
        .cfg_error (cfg_error),
        .cfg_load  (cfg_load),
        .cfg_q     (cfg_q),
        .kind_q    (kind_q)
    );

    // --------------------
    // execute
    // --------------------
    tile_loop_sequencer i_tile_loop_sequencer (
        .clk         (clk),
        .rst         (rst),
        .cfg_load    (cfg_load),
        .cfg         (cfg_q),
        .kind        (kind_q),
        .stall       (stall),
        .coord_valid (coord_valid),
        .coord       (coord),
        .coord_last  (coord_last)
    );

    dma_addr_generator i_dma_addr_generator (
        .clk          (clk),
        .rst          (rst),
        .coord_valid  (coord_valid),
        .coord        (coord),
        .coord_last   (coord_last),
        .cfg          (cfg_q),
        .stall        (stall),
        .cmd_in_valid (cmd_in_valid),
        .cmd_in       (cmd_in),
        .cmd_in_last  (cmd_in_last)
    );

    // --------------------
    // result
    // --------------------
    dma_cmd_issuer i_dma_cmd_issuer (
        .clk           (clk),
        .rst           (rst),
        .cmd_in_valid  (cmd_in_valid),
        .cmd_in        (cmd_in),
        .cmd_in_last   (cmd_in_last),
        .dma_busy      (dma_busy),
        .stall         (stall),
        .dma_cmd_valid (dma_cmd_valid),
        .dma_cmd       (dma_cmd),
        .done          (done)
    );

endmodule

// File: hw/dma_cmd_issuer.sv
`timescale 1ns/10ps
/*
 * dma command issuer
 * two-entry command FIFO, strobes the head out while the DMA is idle
 * and pulses done after the last command
 */
module dma_cmd_issuer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_in_valid,
    input  tile_dma_pkg::dma_cmd_t cmd_in,
    input  logic                   cmd_in_last,
    input  logic                   dma_busy,
    output logic                   stall,
    output logic                   dma_cmd_valid,
    output tile_dma_pkg::dma_cmd_t dma_cmd,
    output logic                   done
);

    tile_dma_pkg::dma_cmd_t fifo_cmd [2];
    logic [1:0]             fifo_last;
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic [1:0]             count_next;
    logic                   wr_en;
    logic                   rd_en;
    logic                   issued_last;

    // stall mirrors a full buffer
    assign wr_en = cmd_in_valid && !stall;
    // idle DMA plus one gap cycle after each strobe
    assign rd_en = (count != 2'd0) && !dma_busy && !dma_cmd_valid;

    always_comb begin
        count_next = count;
        unique case ({wr_en, rd_en})
            2'b10:   count_next = count + 2'd1;
            2'b01:   count_next = count - 2'd1;
            default: ;
        endcase
    end

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count         <= 2'd0;
            wr_ptr        <= 1'b0;
            rd_ptr        <= 1'b0;
            stall         <= 1'b0;
            dma_cmd_valid <= 1'b0;
            issued_last   <= 1'b0;
            done          <= 1'b0;
        end else begin
            count         <= count_next;
            // high once an arrival takes the last slot
            stall         <= (count_next == 2'd2);
            wr_ptr        <= wr_ptr ^ wr_en;
            rd_ptr        <= rd_ptr ^ rd_en;
            dma_cmd_valid <= rd_en;
            if (rd_en) begin
                issued_last <= fifo_last[rd_ptr];
            end
            // cycle after the last strobe
            done <= dma_cmd_valid && issued_last;
        end
    end

    // storage and held output command
    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo_cmd[wr_ptr]  <= cmd_in;
            fifo_last[wr_ptr] <= cmd_in_last;
        end
        if (rd_en) begin
            dma_cmd <= fifo_cmd[rd_ptr];
        end
    end

    // DMA raises busy only after a strobe
    assert property (@(posedge clk) disable iff (rst) dma_cmd_valid |-> !dma_busy);

    // full buffer, generator keeps its command until a slot frees
    assert property (@(posedge clk) disable iff (rst)
        (cmd_in_valid && count == 2'd2) |=> cmd_in_valid && $stable(cmd_in));

endmodule

// File: hw/dma_addr_generator.sv
`timescale 1ns/10ps
/*
 * dma address generator
 * one registered stage mapping a tile coordinate to a 2d dma read,
 * with the row halo for depthwise ifmap tiles
 */
module dma_addr_generator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      coord_valid,
    input  tile_dma_pkg::tile_coord_t coord,
    input  logic                      coord_last,
    input  tile_dma_pkg::layer_cfg_t  cfg,
    input  logic                      stall,
    output logic                      cmd_in_valid,
    output tile_dma_pkg::dma_cmd_t    cmd_in,
    output logic                      cmd_in_last
);

    tile_dma_pkg::addr_t    elem_b;
    tile_dma_pkg::addr_t    plane;
    tile_dma_pkg::dim_t     first_row;
    tile_dma_pkg::dim_t     end_row;
    tile_dma_pkg::dim_t     last_row;
    tile_dma_pkg::dim_t     row0;
    tile_dma_pkg::dim_t     nrows;
    tile_dma_pkg::dim_t     bias_elems;
    logic                   is_dw;
    tile_dma_pkg::dma_cmd_t cmd_next;

    assign is_dw  = (cfg.layer_type == tile_dma_pkg::DW);
    assign elem_b = tile_dma_pkg::addr_t'(tile_dma_pkg::DATA_BYTES);
    // bytes per ifmap channel
    assign plane  = tile_dma_pkg::addr_t'(cfg.in_r) * tile_dma_pkg::addr_t'(cfg.in_c) * elem_b;

    // --------------------
    // dw halo
    // --------------------
    // one row above, clamped at the top edge
    assign first_row = (coord.r0 == '0) ? '0 : coord.r0 - 7'd1;
    // one row below, clamped at the bottom edge
    assign end_row   = coord.r0 + coord.rows;
    assign last_row  = (end_row > cfg.in_r - 7'd1) ? cfg.in_r - 7'd1 : end_row;

    assign row0  = is_dw ? first_row : coord.r0;
    assign nrows = is_dw ? (last_row - first_row + 7'd1) : coord.rows;

    assign bias_elems = is_dw ? cfg.in_d : cfg.out_k;

    always_comb begin
        cmd_next = '0;
        unique case (coord.kind)
            tile_dma_pkg::FETCH_IFMAP: begin
                cmd_next.addr   = cfg.base_ifmap + tile_dma_pkg::addr_t'(coord.d0) * plane +
                                  tile_dma_pkg::addr_t'(row0) *
                                  tile_dma_pkg::addr_t'(cfg.in_c) * elem_b;
                cmd_next.len    = tile_dma_pkg::len_t'(tile_dma_pkg::addr_t'(nrows) *
                                  tile_dma_pkg::addr_t'(cfg.in_c) * elem_b);
                cmd_next.stride = tile_dma_pkg::len_t'(plane);
                cmd_next.count  = tile_dma_pkg::cnt_t'(coord.chans);
            end
            tile_dma_pkg::FETCH_WEIGHT: begin
                if (is_dw) begin
                    // [d][9], whole kernels per channel
                    cmd_next.addr  = cfg.base_weight + tile_dma_pkg::addr_t'(coord.d0) *
                                     tile_dma_pkg::addr_t'(tile_dma_pkg::KERNEL_TAPS) * elem_b;
                    cmd_next.len   = tile_dma_pkg::len_t'(tile_dma_pkg::addr_t'(coord.chans) *
                                     tile_dma_pkg::addr_t'(tile_dma_pkg::KERNEL_TAPS) * elem_b);
                    cmd_next.count = 8'd1;
                end else begin
                    // [k][d], one burst per filter
                    cmd_next.addr   = cfg.base_weight + (tile_dma_pkg::addr_t'(coord.k0) *
                                      tile_dma_pkg::addr_t'(cfg.in_d) +
                                      tile_dma_pkg::addr_t'(coord.d0)) * elem_b;
                    cmd_next.len    = tile_dma_pkg::len_t'(tile_dma_pkg::addr_t'(coord.chans) *
                                      elem_b);
                    cmd_next.stride = tile_dma_pkg::len_t'(tile_dma_pkg::addr_t'(cfg.in_d) *
                                      elem_b);
                    cmd_next.count  = tile_dma_pkg::cnt_t'(coord.filts);
                end
            end
            tile_dma_pkg::FETCH_BIAS: begin
                cmd_next.addr  = cfg.base_bias;
                cmd_next.len   = tile_dma_pkg::len_t'(bias_elems) *
                                 tile_dma_pkg::len_t'(tile_dma_pkg::PSUM_BYTES);
                cmd_next.count = 8'd1;
            end
            default: ;
        endcase
    end

    // stage frozen while the issuer is full
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_in_valid <= 1'b0;
        end else if (!stall) begin
            cmd_in_valid <= coord_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            cmd_in      <= cmd_next;
            cmd_in_last <= coord_last;
        end
    end

endmodule

// File: hw/tile_loop_sequencer.sv
`timescale 1ns/10ps
/*
 * tile loop sequencer
 * walks the tile loops picked by fetch kind and layer type and
 * emits one clipped tile coordinate per cycle unless stalled
 */
module tile_loop_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_load,
    input  tile_dma_pkg::layer_cfg_t  cfg,
    input  tile_dma_pkg::fetch_kind_t kind,
    input  logic                      stall,
    output logic                      coord_valid,
    output tile_dma_pkg::tile_coord_t coord,
    output logic                      coord_last
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } state_t;

    state_t             state;
    tile_dma_pkg::dim_t r0;
    tile_dma_pkg::dim_t d0;
    tile_dma_pkg::dim_t k0;
    tile_dma_pkg::dim_t rem_r;
    tile_dma_pkg::dim_t rem_d;
    tile_dma_pkg::dim_t rem_k;
    logic               r_last;
    logic               d_last;
    logic               k_last;
    logic               pw_weight;
    logic               tile_last;

    // --------------------
    // clipping
    // --------------------
    assign rem_r = cfg.in_r - r0;
    assign rem_d = cfg.in_d - d0;
    assign rem_k = cfg.out_k - k0;

    // tile reaches the end of its dimension
    assign r_last = (rem_r <= cfg.tile_r);
    assign d_last = (rem_d <= cfg.tile_d);
    assign k_last = (rem_k <= cfg.tile_k);

    assign pw_weight = (kind == tile_dma_pkg::FETCH_WEIGHT) &&
                       (cfg.layer_type == tile_dma_pkg::PW);

    always_comb begin
        unique case (kind)
            tile_dma_pkg::FETCH_IFMAP:  tile_last = r_last && d_last;
            tile_dma_pkg::FETCH_WEIGHT: tile_last = pw_weight ? (d_last && k_last) : d_last;
            // bias is one step
            default:                    tile_last = 1'b1;
        endcase
    end

    // --------------------
    // loop FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            coord_valid <= 1'b0;
            coord_last  <= 1'b0;
            r0          <= '0;
            d0          <= '0;
            k0          <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (cfg_load) begin
                        r0    <= '0;
                        d0    <= '0;
                        k0    <= '0;
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (!stall) begin
                        coord_valid <= 1'b1;
                        coord_last  <= tile_last;
                        if (tile_last) begin
                            state <= FINISH;
                        end else if (kind == tile_dma_pkg::FETCH_IFMAP) begin
                            // rows inner, channels outer
                            if (r_last) begin
                                r0 <= '0;
                                d0 <= d0 + cfg.tile_d;
                            end else begin
                                r0 <= r0 + cfg.tile_r;
                            end
                        end else if (pw_weight) begin
                            // channels inner, filters outer
                            if (d_last) begin
                                d0 <= '0;
                                k0 <= k0 + cfg.tile_k;
                            end else begin
                                d0 <= d0 + cfg.tile_d;
                            end
                        end else begin
                            d0 <= d0 + cfg.tile_d;
                        end
                    end
                end
                FINISH: begin
                    // last tile taken downstream
                    if (!stall) begin
                        coord_valid <= 1'b0;
                        coord_last  <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RUN && !stall) begin
            coord.kind  <= kind;
            coord.r0    <= r0;
            coord.d0    <= d0;
            coord.k0    <= k0;
            coord.rows  <= r_last ? rem_r : cfg.tile_r;
            coord.chans <= d_last ? rem_d : cfg.tile_d;
            coord.filts <= k_last ? rem_k : cfg.tile_k;
        end
    end

    // origins stay inside the latched layer
    assert property (@(posedge clk) disable iff (rst)
        coord_valid |-> (coord.r0 < cfg.in_r) && (coord.d0 < cfg.in_d));

endmodule

// File: hw/layer_cfg_decoder.sv
`timescale 1ns/10ps
/*
 * layer config decoder
 * checks the descriptor on start, latches it with the fetch kind
 * and holds busy until the issuer reports done
 */
module layer_cfg_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  tile_dma_pkg::layer_cfg_t  cfg,
    input  tile_dma_pkg::fetch_kind_t kind,
    input  logic                      done,
    output logic                      busy,
    output logic                      cfg_error,
    output logic                      cfg_load,
    output tile_dma_pkg::layer_cfg_t  cfg_q,
    output tile_dma_pkg::fetch_kind_t kind_q
);

    logic accept;
    logic bad_tile;
    logic bad_kdim;
    logic good;

    // start during a fetch is dropped
    assign accept = start && !busy;

    // row and channel tiles must be nonzero and fit the input
    assign bad_tile = (cfg.tile_r == '0) || (cfg.tile_d == '0) ||
                      (cfg.tile_r > cfg.in_r) || (cfg.tile_d > cfg.in_d);

    // filter tile only walked by pw weight fetches
    assign bad_kdim = (kind == tile_dma_pkg::FETCH_WEIGHT) &&
                      (cfg.layer_type == tile_dma_pkg::PW) &&
                      ((cfg.tile_k == '0) || (cfg.tile_k > cfg.out_k));

    assign good = accept && !(bad_tile || bad_kdim);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cfg_error <= 1'b0;
            cfg_load  <= 1'b0;
        end else begin
            cfg_error <= accept && !good;
            cfg_load  <= good;
            // busy rises with cfg_load, falls after done
            if (good) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // descriptor held for the whole fetch
    always_ff @(posedge clk) begin
        if (good) begin
            cfg_q  <= cfg;
            kind_q <= kind;
        end
    end

    // done only closes an accepted fetch
    assert property (@(posedge clk) disable iff (rst) done |-> busy);

endmodule

// File: hw/tile_dma_pkg.sv
/*
 * tile dma package
 * element sizes, vector types, fetch encodings and the structs
 * passed between the decoder, sequencer, address generator and issuer
 */
package tile_dma_pkg;

    // --------------------
    // element sizes
    // --------------------
    // ifmap and weight elements
    localparam int DATA_BYTES = 1;
    // bias kept at psum width
    localparam int PSUM_BYTES = 2;
    // 3x3 depthwise kernel
    localparam int KERNEL_TAPS = 9;

    // --------------------
    // vector types
    // --------------------
    // dimension or tile index
    typedef logic [6:0] dim_t;
    // dram byte address
    typedef logic [31:0] addr_t;
    // burst length or stride in bytes
    typedef logic [15:0] len_t;
    // burst repeat count
    typedef logic [7:0] cnt_t;

    typedef enum logic [1:0] {
        PW = 2'd0,
        DW = 2'd1
    } layer_type_t;

    typedef enum logic [1:0] {
        FETCH_IFMAP  = 2'd0,
        FETCH_WEIGHT = 2'd1,
        FETCH_BIAS   = 2'd2
    } fetch_kind_t;

    // --------------------
    // structs
    // --------------------
    // layer descriptor from software
    typedef struct packed {
        layer_type_t layer_type;
        dim_t        in_r;
        dim_t        in_c;
        dim_t        in_d;
        dim_t        out_k;
        dim_t        tile_r;
        dim_t        tile_d;
        dim_t        tile_k;
        addr_t       base_ifmap;
        addr_t       base_weight;
        addr_t       base_bias;
    } layer_cfg_t;

    // one tile, origins plus clipped extents
    typedef struct packed {
        fetch_kind_t kind;
        dim_t        r0;
        dim_t        d0;
        dim_t        k0;
        dim_t        rows;
        dim_t        chans;
        dim_t        filts;
    } tile_coord_t;

    // count bursts of len bytes, stride bytes apart
    typedef struct packed {
        addr_t addr;
        len_t  len;
        len_t  stride;
        cnt_t  count;
    } dma_cmd_t;

endpackage
